// File: src/zynq_bridge_cfg.svh
`ifndef ZYNQ_BRIDGE_CFG_SVH
`define ZYNQ_BRIDGE_CFG_SVH

// control bus address width
`define ZB_AXIL_ADDR_W 8
// bus data width, also the DRAM address width
`define ZB_DATA_W 32

// where the core sees the start of its DRAM
`define ZB_DRAM_BP_BASE 32'h8000_0000
// the host only hands out 256 MB to the core
`define ZB_MEM_LIMIT 32'h1000_0000

// region field of a DRAM address, bits 29 down to 23
`define ZB_REGION_MSB 29
`define ZB_REGION_W 7
`define ZB_NUM_REGIONS 128

`endif

// File: src/axil_pkg.sv
`include "zynq_bridge_cfg.svh"

package axil_pkg;

   // only the two codes this slave ever returns
   typedef enum logic [1:0] {
      AXIL_RESP_OKAY   = 2'b00,
      AXIL_RESP_SLVERR = 2'b10
   } axil_resp_e;

   typedef logic [`ZB_AXIL_ADDR_W-1:0] axil_addr_t;
   typedef logic [`ZB_DATA_W-1:0]      axil_data_t;

endpackage

// File: src/bridge_pkg.sv
`include "zynq_bridge_cfg.svh"

package bridge_pkg;

   // byte offsets of the control registers
   typedef enum logic [`ZB_AXIL_ADDR_W-1:0] {
      CSR_CTRL      = 8'h00,
      CSR_DRAM_BASE = 8'h08,
      CSR_PROF0     = 8'h10,
      CSR_PROF1     = 8'h14,
      CSR_PROF2     = 8'h18,
      CSR_PROF3     = 8'h1C,
      CSR_OVER_CNT  = 8'h20
   } csr_reg_e;

   typedef logic [`ZB_DATA_W-1:0] dram_addr_t;

   // one region is 8 MB of DRAM
   typedef logic [`ZB_REGION_W-1:0] region_t;

   // one sticky bit per region
   typedef logic [`ZB_NUM_REGIONS-1:0] prof_map_t;

endpackage

// File: src/axil_if.sv
`timescale 1ns/1ps
`include "zynq_bridge_cfg.svh"

interface axil_if ();
   import axil_pkg::*;

   axil_addr_t              awaddr;
   logic                    awvalid;
   logic                    awready;
   axil_data_t              wdata;
   logic [`ZB_DATA_W/8-1:0] wstrb;
   logic                    wvalid;
   logic                    wready;
   axil_resp_e              bresp;
   logic                    bvalid;
   logic                    bready;
   axil_addr_t              araddr;
   logic                    arvalid;
   logic                    arready;
   axil_data_t              rdata;
   axil_resp_e              rresp;
   logic                    rvalid;
   logic                    rready;

   modport master (
      output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
      input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
   );

   modport slave (
      input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
      output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
   );

endinterface

// File: src/axil_csr_shell.sv
`timescale 1ns/1ps
`include "zynq_bridge_cfg.svh"

module axil_csr_shell (
   input  logic                   aclk_i,
   input  logic                   arst_n_i,
   axil_if.slave                  bus,
   input  bridge_pkg::prof_map_t  prof_map_i,
   input  logic [`ZB_DATA_W-1:0]  over_cnt_i,
   output bridge_pkg::dram_addr_t dram_base_o,
   output logic                   core_reset_o
);
   import axil_pkg::*;
   import bridge_pkg::*;

   // first offset past the register map, from here on the slave answers SLVERR
   localparam axil_addr_t csr_end_lp = axil_addr_t'(CSR_OVER_CNT) + axil_addr_t'(4);

   logic       ctrl_q;
   dram_addr_t base_q;
   logic       bvalid_q;
   axil_resp_e bresp_q;
   logic       rvalid_q;
   axil_data_t rdata_q;
   axil_resp_e rresp_q;
   axil_data_t rdata_d;
   logic       wr_hs;
   logic       rd_hs;

   // AW and W are taken in the same cycle, one write in flight at most
   assign wr_hs = bus.awvalid & bus.wvalid & ~bvalid_q;
   assign rd_hs = bus.arvalid & ~rvalid_q;

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ctrl_q   <= 1'b0;
         base_q   <= '0;
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         if (wr_hs) begin
            bvalid_q <= 1'b1;
            // writes to the status words fall through to default and are dropped
            case (bus.awaddr)
               CSR_CTRL: begin
                  if (bus.wstrb[0]) begin
                     ctrl_q <= bus.wdata[0];
                  end
               end
               CSR_DRAM_BASE: begin
                  for (int b = 0; b < `ZB_DATA_W/8; b++) begin
                     if (bus.wstrb[b]) begin
                        base_q[8*b +: 8] <= bus.wdata[8*b +: 8];
                     end
                  end
               end
               default: begin
               end
            endcase
         end else if (bus.bready) begin
            bvalid_q <= 1'b0;
         end

         if (rd_hs) begin
            rvalid_q <= 1'b1;
         end else if (bus.rready) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge aclk_i) begin
      if (wr_hs) begin
         bresp_q <= (bus.awaddr < csr_end_lp) ? AXIL_RESP_OKAY : AXIL_RESP_SLVERR;
      end
      if (rd_hs) begin
         rdata_q <= rdata_d;
         rresp_q <= (bus.araddr < csr_end_lp) ? AXIL_RESP_OKAY : AXIL_RESP_SLVERR;
      end
   end

   // holes in the map and out of range offsets read as zero
   always_comb begin
      case (bus.araddr)
         CSR_CTRL:      rdata_d = axil_data_t'(ctrl_q);
         CSR_DRAM_BASE: rdata_d = base_q;
         CSR_PROF0:     rdata_d = prof_map_i[31:0];
         CSR_PROF1:     rdata_d = prof_map_i[63:32];
         CSR_PROF2:     rdata_d = prof_map_i[95:64];
         CSR_PROF3:     rdata_d = prof_map_i[127:96];
         CSR_OVER_CNT:  rdata_d = over_cnt_i;
         default:       rdata_d = '0;
      endcase
   end

   assign bus.awready = wr_hs;
   assign bus.wready  = wr_hs;
   assign bus.bvalid  = bvalid_q;
   assign bus.bresp   = bresp_q;
   assign bus.arready = ~rvalid_q;
   assign bus.rvalid  = rvalid_q;
   assign bus.rdata   = rdata_q;
   assign bus.rresp   = rresp_q;

   assign dram_base_o = base_q;

   // the core stays in reset until the host sets CTRL bit 0
   // and the async clear of ctrl_q puts it back there on a bus reset
   assign core_reset_o = ~ctrl_q;

   a_bvalid_hold: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      bvalid_q && !bus.bready |=> bvalid_q);

endmodule

// File: src/dram_addr_chan.sv
`timescale 1ns/1ps
`include "zynq_bridge_cfg.svh"

module dram_addr_chan (
   input  logic                   aclk_i,
   input  logic                   arst_n_i,
   input  logic                   core_reset_i,
   input  bridge_pkg::dram_addr_t dram_base_i,
   input  bridge_pkg::dram_addr_t addr_i,
   input  logic                   valid_i,
   output logic                   ready_o,
   output bridge_pkg::dram_addr_t addr_o,
   output logic                   valid_o,
   input  logic                   ready_i,
   output logic                   evt_v_o,
   output bridge_pkg::region_t    evt_region_o,
   output logic                   evt_over_o
);
   import bridge_pkg::*;

   dram_addr_t offset;
   dram_addr_t host_addr;
   dram_addr_t addr_q;
   logic       valid_q;
   logic       in_hs;

   // xor strips the core DRAM base, then the host buffer base is added on
   assign offset    = addr_i ^ `ZB_DRAM_BP_BASE;
   assign host_addr = offset + dram_base_i;

   // a full slice still takes a new address when its own entry leaves this cycle
   assign ready_o = ~valid_q | ready_i;
   assign in_hs   = valid_i & ready_o;

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_q <= 1'b0;
      end else if (core_reset_i) begin
         valid_q <= 1'b0;
      end else if (in_hs) begin
         valid_q <= 1'b1;
      end else if (ready_i) begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge aclk_i) begin
      if (in_hs) begin
         addr_q <= host_addr;
      end
   end

   assign addr_o  = addr_q;
   assign valid_o = valid_q;

   // profiler events go out with the input handshake, not the output one
   assign evt_v_o      = in_hs;
   assign evt_region_o = host_addr[`ZB_REGION_MSB -: `ZB_REGION_W];
   assign evt_over_o   = offset >= `ZB_MEM_LIMIT;

   a_addr_stable: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      valid_o && !ready_i |=> $stable(addr_o));

endmodule

// File: src/mem_profiler.sv
`timescale 1ns/1ps
`include "zynq_bridge_cfg.svh"

module mem_profiler (
   input  logic                  aclk_i,
   input  logic                  arst_n_i,
   input  logic                  core_reset_i,
   input  logic                  wr_evt_v_i,
   input  bridge_pkg::region_t   wr_evt_region_i,
   input  logic                  wr_evt_over_i,
   input  logic                  rd_evt_v_i,
   input  bridge_pkg::region_t   rd_evt_region_i,
   input  logic                  rd_evt_over_i,
   output bridge_pkg::prof_map_t prof_map_o,
   output logic [`ZB_DATA_W-1:0] over_cnt_o
);
   import bridge_pkg::*;

   prof_map_t             map_q;
   prof_map_t             wr_mask;
   prof_map_t             rd_mask;
   logic [`ZB_DATA_W-1:0] cnt_q;
   logic [1:0]            cnt_inc;
   logic [`ZB_DATA_W:0]   cnt_sum;

   assign wr_mask = prof_map_t'(wr_evt_v_i) << wr_evt_region_i;
   assign rd_mask = prof_map_t'(rd_evt_v_i) << rd_evt_region_i;

   // both channels can go over the limit in the same cycle
   assign cnt_inc = {1'b0, wr_evt_v_i & wr_evt_over_i} + {1'b0, rd_evt_v_i & rd_evt_over_i};
   assign cnt_sum = {1'b0, cnt_q} + {{(`ZB_DATA_W-1){1'b0}}, cnt_inc};

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         map_q <= '0;
         cnt_q <= '0;
      end else if (core_reset_i) begin
         map_q <= '0;
         cnt_q <= '0;
      end else begin
         map_q <= map_q | wr_mask | rd_mask;
         // the count sticks at all ones rather than wrap
         if (cnt_sum[`ZB_DATA_W]) begin
            cnt_q <= '1;
         end else begin
            cnt_q <= cnt_sum[`ZB_DATA_W-1:0];
         end
      end
   end

   assign prof_map_o = map_q;
   assign over_cnt_o = cnt_q;

endmodule

// File: src/zynq_bridge_top.sv
`timescale 1ns/1ps
`include "zynq_bridge_cfg.svh"

module zynq_bridge_top (
   input  logic                    aclk_i,
   input  logic                    arst_n_i,
   input  axil_pkg::axil_addr_t    s_axil_awaddr_i,
   input  logic                    s_axil_awvalid_i,
   output logic                    s_axil_awready_o,
   input  axil_pkg::axil_data_t    s_axil_wdata_i,
   input  logic [`ZB_DATA_W/8-1:0] s_axil_wstrb_i,
   input  logic                    s_axil_wvalid_i,
   output logic                    s_axil_wready_o,
   output axil_pkg::axil_resp_e    s_axil_bresp_o,
   output logic                    s_axil_bvalid_o,
   input  logic                    s_axil_bready_i,
   input  axil_pkg::axil_addr_t    s_axil_araddr_i,
   input  logic                    s_axil_arvalid_i,
   output logic                    s_axil_arready_o,
   output axil_pkg::axil_data_t    s_axil_rdata_o,
   output axil_pkg::axil_resp_e    s_axil_rresp_o,
   output logic                    s_axil_rvalid_o,
   input  logic                    s_axil_rready_i,
   input  bridge_pkg::dram_addr_t  core_aw_addr_i,
   input  logic                    core_aw_valid_i,
   output logic                    core_aw_ready_o,
   input  bridge_pkg::dram_addr_t  core_ar_addr_i,
   input  logic                    core_ar_valid_i,
   output logic                    core_ar_ready_o,
   output bridge_pkg::dram_addr_t  m_aw_addr_o,
   output logic                    m_aw_valid_o,
   input  logic                    m_aw_ready_i,
   output bridge_pkg::dram_addr_t  m_ar_addr_o,
   output logic                    m_ar_valid_o,
   input  logic                    m_ar_ready_i,
   output logic                    core_reset_o
);
   import bridge_pkg::*;

   axil_if axil_bus ();

   dram_addr_t            dram_base;
   logic                  core_reset;
   logic                  wr_evt_v;
   region_t               wr_evt_region;
   logic                  wr_evt_over;
   logic                  rd_evt_v;
   region_t               rd_evt_region;
   logic                  rd_evt_over;
   prof_map_t             prof_map;
   logic [`ZB_DATA_W-1:0] over_cnt;

   // host control port onto the internal bus
   assign axil_bus.awaddr  = s_axil_awaddr_i;
   assign axil_bus.awvalid = s_axil_awvalid_i;
   assign axil_bus.wdata   = s_axil_wdata_i;
   assign axil_bus.wstrb   = s_axil_wstrb_i;
   assign axil_bus.wvalid  = s_axil_wvalid_i;
   assign axil_bus.bready  = s_axil_bready_i;
   assign axil_bus.araddr  = s_axil_araddr_i;
   assign axil_bus.arvalid = s_axil_arvalid_i;
   assign axil_bus.rready  = s_axil_rready_i;
   assign s_axil_awready_o = axil_bus.awready;
   assign s_axil_wready_o  = axil_bus.wready;
   assign s_axil_bresp_o   = axil_bus.bresp;
   assign s_axil_bvalid_o  = axil_bus.bvalid;
   assign s_axil_arready_o = axil_bus.arready;
   assign s_axil_rdata_o   = axil_bus.rdata;
   assign s_axil_rresp_o   = axil_bus.rresp;
   assign s_axil_rvalid_o  = axil_bus.rvalid;

   assign core_reset_o = core_reset;

   axil_csr_shell u_shell (
      .aclk_i(aclk_i), .arst_n_i(arst_n_i), .bus(axil_bus.slave),
      .prof_map_i(prof_map), .over_cnt_i(over_cnt),
      .dram_base_o(dram_base), .core_reset_o(core_reset)
   );

   dram_addr_chan u_wr_chan (
      .aclk_i(aclk_i), .arst_n_i(arst_n_i), .core_reset_i(core_reset),
      .dram_base_i(dram_base),
      .addr_i(core_aw_addr_i), .valid_i(core_aw_valid_i), .ready_o(core_aw_ready_o),
      .addr_o(m_aw_addr_o), .valid_o(m_aw_valid_o), .ready_i(m_aw_ready_i),
      .evt_v_o(wr_evt_v), .evt_region_o(wr_evt_region), .evt_over_o(wr_evt_over)
   );

   dram_addr_chan u_rd_chan (
      .aclk_i(aclk_i), .arst_n_i(arst_n_i), .core_reset_i(core_reset),
      .dram_base_i(dram_base),
      .addr_i(core_ar_addr_i), .valid_i(core_ar_valid_i), .ready_o(core_ar_ready_o),
      .addr_o(m_ar_addr_o), .valid_o(m_ar_valid_o), .ready_i(m_ar_ready_i),
      .evt_v_o(rd_evt_v), .evt_region_o(rd_evt_region), .evt_over_o(rd_evt_over)
   );

   mem_profiler u_profiler (
      .aclk_i(aclk_i), .arst_n_i(arst_n_i), .core_reset_i(core_reset),
      .wr_evt_v_i(wr_evt_v), .wr_evt_region_i(wr_evt_region), .wr_evt_over_i(wr_evt_over),
      .rd_evt_v_i(rd_evt_v), .rd_evt_region_i(rd_evt_region), .rd_evt_over_i(rd_evt_over),
      .prof_map_o(prof_map), .over_cnt_o(over_cnt)
   );

endmodule

// File: verification/bridge_checker.sv
`timescale 1ns/1ps
`include "zynq_bridge_cfg.svh"

module bridge_checker (
   input logic                    aclk_i,
   input logic                    arst_n_i,
   input axil_pkg::axil_addr_t    awaddr_i,
   input logic                    awvalid_i,
   input logic                    awready_i,
   input axil_pkg::axil_data_t    wdata_i,
   input logic [`ZB_DATA_W/8-1:0] wstrb_i,
   input logic                    wvalid_i,
   input logic                    wready_i,
   input axil_pkg::axil_resp_e    bresp_i,
   input logic                    bvalid_i,
   input logic                    bready_i,
   input axil_pkg::axil_addr_t    araddr_i,
   input logic                    arvalid_i,
   input logic                    arready_i,
   input axil_pkg::axil_data_t    rdata_i,
   input axil_pkg::axil_resp_e    rresp_i,
   input logic                    rvalid_i,
   input logic                    rready_i,
   input bridge_pkg::dram_addr_t  core_aw_addr_i,
   input logic                    core_aw_valid_i,
   input logic                    core_aw_ready_i,
   input bridge_pkg::dram_addr_t  core_ar_addr_i,
   input logic                    core_ar_valid_i,
   input logic                    core_ar_ready_i,
   input bridge_pkg::dram_addr_t  m_aw_addr_i,
   input logic                    m_aw_valid_i,
   input logic                    m_aw_ready_i,
   input bridge_pkg::dram_addr_t  m_ar_addr_i,
   input logic                    m_ar_valid_i,
   input logic                    m_ar_ready_i,
   input logic                    core_reset_i
);
   import axil_pkg::*;
   import bridge_pkg::*;

   int          err_cnt = 0;
   int          chk_cnt = 0;
   int          pending = 0;
   logic        in_reset = 1'b0;
   logic        ctrl_m;
   dram_addr_t  base_m;
   prof_map_t   map_m;
   logic [31:0] cnt_m;
   dram_addr_t  aw_exp[$];
   dram_addr_t  ar_exp[$];
   axil_data_t  rdata_exp[$];
   logic [1:0]  rresp_exp[$];
   logic [1:0]  bresp_exp[$];

   // host address = core address with the core DRAM base stripped, plus the host base
   function automatic dram_addr_t xlate(input dram_addr_t a, input dram_addr_t base);
      return (a ^ `ZB_DRAM_BP_BASE) + base;
   endfunction

   function automatic axil_data_t reg_value(input axil_addr_t a);
      case (a)
         CSR_CTRL:      return axil_data_t'(ctrl_m);
         CSR_DRAM_BASE: return base_m;
         CSR_PROF0:     return map_m[31:0];
         CSR_PROF1:     return map_m[63:32];
         CSR_PROF2:     return map_m[95:64];
         CSR_PROF3:     return map_m[127:96];
         CSR_OVER_CNT:  return cnt_m;
         default:       return '0;
      endcase
   endfunction

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic profile(input dram_addr_t a);
      dram_addr_t h;
      h = xlate(a, base_m);
      map_m[h[`ZB_REGION_MSB -: `ZB_REGION_W]] = 1'b1;
      if (((a ^ `ZB_DRAM_BP_BASE) >= `ZB_MEM_LIMIT) && (cnt_m != '1)) begin
         cnt_m++;
      end
   endtask

   // everything is sampled at the rising edge, before the DUT registers update
   always @(posedge aclk_i) begin
      if (!arst_n_i) begin
         if (in_reset) begin
            compare("s_axil_bvalid_o", bvalid_i, 0);
            compare("s_axil_rvalid_o", rvalid_i, 0);
            compare("m_aw_valid_o", m_aw_valid_i, 0);
            compare("m_ar_valid_o", m_ar_valid_i, 0);
            compare("core_reset_o", core_reset_i, 1);
         end
         in_reset = 1'b1;
         ctrl_m = 1'b0;
         base_m = '0;
         map_m = '0;
         cnt_m = '0;
         aw_exp.delete();
         ar_exp.delete();
         rdata_exp.delete();
         rresp_exp.delete();
         bresp_exp.delete();
      end else begin
         compare("core_reset_o", core_reset_i, !ctrl_m);

         // valids follow the pending responses and what each slice holds
         compare("s_axil_bvalid_o", bvalid_i, bresp_exp.size() != 0);
         compare("s_axil_rvalid_o", rvalid_i, rdata_exp.size() != 0);
         compare("m_aw_valid_o", m_aw_valid_i, aw_exp.size() != 0);
         compare("m_ar_valid_o", m_ar_valid_i, ar_exp.size() != 0);

         // AW and W go in together and only while no write response is pending
         compare("s_axil_awready_o", awready_i,
                 awvalid_i && wvalid_i && (bresp_exp.size() == 0));
         compare("s_axil_wready_o", wready_i,
                 awvalid_i && wvalid_i && (bresp_exp.size() == 0));
         if (arvalid_i) begin
            compare("s_axil_arready_o", arready_i, rdata_exp.size() == 0);
         end

         // a slice takes input when empty or when its entry leaves this cycle
         compare("core_aw_ready_o", core_aw_ready_i, (aw_exp.size() == 0) || m_aw_ready_i);
         compare("core_ar_ready_o", core_ar_ready_i, (ar_exp.size() == 0) || m_ar_ready_i);

         if (m_aw_valid_i && m_aw_ready_i) begin
            if (aw_exp.size() == 0) begin
               err_cnt++;
               $display("unexpected address %h left on m_aw at %0t ns", m_aw_addr_i, $time);
            end else begin
               compare("m_aw_addr_o", m_aw_addr_i, aw_exp.pop_front());
            end
         end
         if (m_ar_valid_i && m_ar_ready_i) begin
            if (ar_exp.size() == 0) begin
               err_cnt++;
               $display("unexpected address %h left on m_ar at %0t ns", m_ar_addr_i, $time);
            end else begin
               compare("m_ar_addr_o", m_ar_addr_i, ar_exp.pop_front());
            end
         end

         if (bvalid_i && bready_i) begin
            if (bresp_exp.size() == 0) begin
               err_cnt++;
               $display("write response at %0t ns without a write", $time);
            end else begin
               compare("s_axil_bresp_o", bresp_i, bresp_exp.pop_front());
            end
         end
         if (rvalid_i && rready_i) begin
            if (rdata_exp.size() == 0) begin
               err_cnt++;
               $display("read response at %0t ns without a read", $time);
            end else begin
               compare("s_axil_rdata_o", rdata_i, rdata_exp.pop_front());
               compare("s_axil_rresp_o", rresp_i, rresp_exp.pop_front());
            end
         end

         // a read sees the state from before this edge
         if (arvalid_i && arready_i) begin
            rdata_exp.push_back(reg_value(araddr_i));
            rresp_exp.push_back((araddr_i < 8'h24) ? 2'b00 : 2'b10);
         end

         // the core reset empties both slices and clears the profile
         if (!ctrl_m) begin
            map_m = '0;
            cnt_m = '0;
            aw_exp.delete();
            ar_exp.delete();
         end else begin
            if (core_aw_valid_i && core_aw_ready_i) begin
               aw_exp.push_back(xlate(core_aw_addr_i, base_m));
               profile(core_aw_addr_i);
            end
            if (core_ar_valid_i && core_ar_ready_i) begin
               ar_exp.push_back(xlate(core_ar_addr_i, base_m));
               profile(core_ar_addr_i);
            end
         end

         if (awvalid_i && awready_i && wvalid_i && wready_i) begin
            bresp_exp.push_back((awaddr_i < 8'h24) ? 2'b00 : 2'b10);
            if (awaddr_i == CSR_CTRL && wstrb_i[0]) begin
               ctrl_m = wdata_i[0];
            end
            if (awaddr_i == CSR_DRAM_BASE) begin
               for (int b = 0; b < `ZB_DATA_W/8; b++) begin
                  if (wstrb_i[b]) begin
                     base_m[8*b +: 8] = wdata_i[8*b +: 8];
                  end
               end
            end
         end
         pending = aw_exp.size() + ar_exp.size();
      end
   end

endmodule

// File: verification/tb_zynq_bridge.sv
`timescale 1ns/1ps
`include "zynq_bridge_cfg.svh"

module tb_zynq_bridge;
   import axil_pkg::*;
   import bridge_pkg::*;

   localparam int clk_period_lp = 100;
   localparam int n_addr_lp = 40;
   // control transfers plus three rounds of core addresses on both channels
   localparam int n_trans_lp = 40 + 6 * n_addr_lp;
   localparam longint timeout_lp = longint'(n_trans_lp * 20 + 1000) * clk_period_lp;

   logic                    aclk;
   logic                    arst_n;
   axil_addr_t              s_axil_awaddr;
   logic                    s_axil_awvalid;
   logic                    s_axil_awready;
   axil_data_t              s_axil_wdata;
   logic [`ZB_DATA_W/8-1:0] s_axil_wstrb;
   logic                    s_axil_wvalid;
   logic                    s_axil_wready;
   axil_resp_e              s_axil_bresp;
   logic                    s_axil_bvalid;
   logic                    s_axil_bready;
   axil_addr_t              s_axil_araddr;
   logic                    s_axil_arvalid;
   logic                    s_axil_arready;
   axil_data_t              s_axil_rdata;
   axil_resp_e              s_axil_rresp;
   logic                    s_axil_rvalid;
   logic                    s_axil_rready;
   dram_addr_t              core_aw_addr;
   logic                    core_aw_valid;
   logic                    core_aw_ready;
   dram_addr_t              core_ar_addr;
   logic                    core_ar_valid;
   logic                    core_ar_ready;
   dram_addr_t              m_aw_addr;
   logic                    m_aw_valid;
   logic                    m_aw_ready;
   dram_addr_t              m_ar_addr;
   logic                    m_ar_valid;
   logic                    m_ar_ready;
   logic                    core_reset;
   integer                  seed;
   logic                    stall_en;
   int                      tests_run;
   int                      err_mark;

   zynq_bridge_top u_dut (
      .aclk_i(aclk), .arst_n_i(arst_n),
      .s_axil_awaddr_i(s_axil_awaddr), .s_axil_awvalid_i(s_axil_awvalid),
      .s_axil_awready_o(s_axil_awready),
      .s_axil_wdata_i(s_axil_wdata), .s_axil_wstrb_i(s_axil_wstrb),
      .s_axil_wvalid_i(s_axil_wvalid), .s_axil_wready_o(s_axil_wready),
      .s_axil_bresp_o(s_axil_bresp), .s_axil_bvalid_o(s_axil_bvalid),
      .s_axil_bready_i(s_axil_bready),
      .s_axil_araddr_i(s_axil_araddr), .s_axil_arvalid_i(s_axil_arvalid),
      .s_axil_arready_o(s_axil_arready),
      .s_axil_rdata_o(s_axil_rdata), .s_axil_rresp_o(s_axil_rresp),
      .s_axil_rvalid_o(s_axil_rvalid), .s_axil_rready_i(s_axil_rready),
      .core_aw_addr_i(core_aw_addr), .core_aw_valid_i(core_aw_valid),
      .core_aw_ready_o(core_aw_ready),
      .core_ar_addr_i(core_ar_addr), .core_ar_valid_i(core_ar_valid),
      .core_ar_ready_o(core_ar_ready),
      .m_aw_addr_o(m_aw_addr), .m_aw_valid_o(m_aw_valid), .m_aw_ready_i(m_aw_ready),
      .m_ar_addr_o(m_ar_addr), .m_ar_valid_o(m_ar_valid), .m_ar_ready_i(m_ar_ready),
      .core_reset_o(core_reset)
   );

   bridge_checker u_chk (
      .aclk_i(aclk), .arst_n_i(arst_n),
      .awaddr_i(s_axil_awaddr), .awvalid_i(s_axil_awvalid), .awready_i(s_axil_awready),
      .wdata_i(s_axil_wdata), .wstrb_i(s_axil_wstrb), .wvalid_i(s_axil_wvalid),
      .wready_i(s_axil_wready),
      .bresp_i(s_axil_bresp), .bvalid_i(s_axil_bvalid), .bready_i(s_axil_bready),
      .araddr_i(s_axil_araddr), .arvalid_i(s_axil_arvalid), .arready_i(s_axil_arready),
      .rdata_i(s_axil_rdata), .rresp_i(s_axil_rresp), .rvalid_i(s_axil_rvalid),
      .rready_i(s_axil_rready),
      .core_aw_addr_i(core_aw_addr), .core_aw_valid_i(core_aw_valid),
      .core_aw_ready_i(core_aw_ready),
      .core_ar_addr_i(core_ar_addr), .core_ar_valid_i(core_ar_valid),
      .core_ar_ready_i(core_ar_ready),
      .m_aw_addr_i(m_aw_addr), .m_aw_valid_i(m_aw_valid), .m_aw_ready_i(m_aw_ready),
      .m_ar_addr_i(m_ar_addr), .m_ar_valid_i(m_ar_valid), .m_ar_ready_i(m_ar_ready),
      .core_reset_i(core_reset)
   );

   initial begin
      aclk = 1'b0;
      forever begin
         #(clk_period_lp/2) aclk = ~aclk;
      end
   end

   initial begin
      #(timeout_lp);
      $display("timeout: the tests did not finish within %0d ns", timeout_lp);
      $display("Errors found");
      $finish;
   end

   // downstream ready, stalled at random while back-pressure is on
   always @(negedge aclk) begin
      m_aw_ready = stall_en ? $random(seed) : 1'b1;
      m_ar_ready = stall_en ? $random(seed) : 1'b1;
   end

   task automatic axil_write(input axil_addr_t a, input axil_data_t d, input logic [3:0] strb);
      @(negedge aclk);
      s_axil_awaddr = a;
      s_axil_wdata = d;
      s_axil_wstrb = strb;
      s_axil_awvalid = 1'b1;
      s_axil_wvalid = 1'b1;
      do @(posedge aclk); while (!s_axil_awready);
      @(negedge aclk);
      s_axil_awvalid = 1'b0;
      s_axil_wvalid = 1'b0;
      do @(posedge aclk); while (!s_axil_bvalid);
   endtask

   task automatic axil_read(input axil_addr_t a);
      @(negedge aclk);
      s_axil_araddr = a;
      s_axil_arvalid = 1'b1;
      do @(posedge aclk); while (!s_axil_arready);
      @(negedge aclk);
      s_axil_arvalid = 1'b0;
      do @(posedge aclk); while (!s_axil_rvalid);
   endtask

   task automatic read_status();
      axil_read(CSR_CTRL);
      axil_read(CSR_PROF0);
      axil_read(CSR_PROF1);
      axil_read(CSR_PROF2);
      axil_read(CSR_PROF3);
      axil_read(CSR_OVER_CNT);
   endtask

   task automatic send_core_addrs(input bit wr, input int n);
      dram_addr_t offset;
      for (int i = 0; i < n; i++) begin
         @(negedge aclk);
         offset = $random(seed);
         // three in four offsets stay inside the 256 MB window
         if (($random(seed) & 3) != 0) begin
            offset[31:28] = 4'h0;
         end
         if (wr) begin
            core_aw_addr = offset ^ `ZB_DRAM_BP_BASE;
            core_aw_valid = 1'b1;
         end else begin
            core_ar_addr = offset ^ `ZB_DRAM_BP_BASE;
            core_ar_valid = 1'b1;
         end
         do @(posedge aclk); while (!(wr ? core_aw_ready : core_ar_ready));
      end
      @(negedge aclk);
      if (wr) begin
         core_aw_valid = 1'b0;
      end else begin
         core_ar_valid = 1'b0;
      end
   endtask

   task automatic run_traffic(input int n);
      fork
         send_core_addrs(1'b1, n);
         send_core_addrs(1'b0, n);
      join
      do @(negedge aclk); while (u_chk.pending != 0);
   endtask

   task automatic end_test(input string name);
      @(negedge aclk);
      tests_run++;
      $display("test %0d %s finished with %0d errors", tests_run, name,
               u_chk.err_cnt - err_mark);
      err_mark = u_chk.err_cnt;
   endtask

   initial begin
      seed = 32'h36bd;
      tests_run = 0;
      err_mark = 0;
      stall_en = 1'b0;
      arst_n = 1'b0;
      s_axil_awaddr = '0;
      s_axil_awvalid = 1'b0;
      s_axil_wdata = '0;
      s_axil_wstrb = '0;
      s_axil_wvalid = 1'b0;
      s_axil_bready = 1'b1;
      s_axil_araddr = '0;
      s_axil_arvalid = 1'b0;
      s_axil_rready = 1'b1;
      core_aw_addr = '0;
      core_aw_valid = 1'b0;
      core_ar_addr = '0;
      core_ar_valid = 1'b0;
      m_aw_ready = 1'b1;
      m_ar_ready = 1'b1;
      repeat (5) @(posedge aclk);
      @(negedge aclk);
      arst_n = 1'b1;

      read_status();
      end_test("reset");

      axil_write(CSR_DRAM_BASE, 32'h1234_5678, 4'hf);
      axil_read(CSR_DRAM_BASE);
      // only bytes 0 and 2 take the new value
      axil_write(CSR_DRAM_BASE, 32'haabb_ccdd, 4'b0101);
      axil_read(CSR_DRAM_BASE);
      axil_write(CSR_PROF0, 32'hffff_ffff, 4'hf);
      axil_read(CSR_PROF0);
      axil_read(8'h04);
      axil_write(8'h40, 32'h0000_0001, 4'hf);
      axil_read(8'h40);
      end_test("register access");

      axil_write(CSR_DRAM_BASE, $random(seed), 4'hf);
      axil_write(CSR_CTRL, 32'h1, 4'h1);
      run_traffic(n_addr_lp);
      end_test("translation");

      @(posedge aclk);
      stall_en = 1'b1;
      run_traffic(n_addr_lp);
      @(posedge aclk);
      stall_en = 1'b0;
      end_test("back-pressure");

      run_traffic(n_addr_lp);
      read_status();
      end_test("profiling");

      axil_write(CSR_CTRL, 32'h0, 4'h1);
      read_status();
      end_test("core reset");

      $display("%0d tests, %0d checks, %0d errors", tests_run, u_chk.chk_cnt, u_chk.err_cnt);
      if (u_chk.err_cnt == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: zynq_bridge.f
+incdir+src
src/axil_pkg.sv
src/bridge_pkg.sv
src/axil_if.sv
src/axil_csr_shell.sv
src/dram_addr_chan.sv
src/mem_profiler.sv
src/zynq_bridge_top.sv
verification/bridge_checker.sv
verification/tb_zynq_bridge.sv
